//--- files.f
bexkat_pkg.sv
bexkat_alu.sv
bexkat_regfile.sv
bexkat_cond.sv
bexkat_control.sv
bexkat_cpu.sv
tb_mem_model.sv
tb_bexkat.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module tb_bexkat -o sim_bexkat

./obj_dir/sim_bexkat | tee sim.log

grep -q "All tests passed!" sim.log

//--- tb_bexkat.sv
`timescale 1ns/1ps

module tb_bexkat;

  localparam logic [31:0] DATA_BASE = 32'h0000_4000;
  localparam logic [31:0] STACK_TOP = 32'h0000_6000;

  logic        csi_clk;
  logic        rsi_reset_n;
  logic        avm_m0_waitrequest;
  logic [15:0] avm_m0_readdata;
  logic [31:0] avm_m0_address;
  logic        avm_m0_read;
  logic        avm_m0_write;
  logic [15:0] avm_m0_writedata;
  logic [1:0]  avm_m0_byteenable;

  logic [15:0] prog[$];
  logic [31:0] rm [32]; // expected register contents
  logic [31:0] shadow [logic [31:0]];
  logic [31:0] exp_addr[$];
  logic [15:0] exp_data[$];
  logic [31:0] exp_read[$];
  logic [31:0] cmp_a, cmp_b;
  logic [31:0] prev_addr;
  logic        prev_busy, prev_stall, prev_read, prev_done;
  string       test_name;
  int          test_err, strobe_err, passes, fails, rd_count;
  int          wd_cycles, wd_limit;

  initial begin
    csi_clk = 1'b0;
    forever #2 csi_clk = ~csi_clk;
  end

  initial begin
    wd_cycles = 0;
    wd_limit = 100;
    while (wd_cycles < wd_limit) begin
      @(posedge csi_clk);
      wd_cycles++;
    end
    $display("TIMEOUT in %s after %0d cycles, %0d writes never came", test_name, wd_cycles,
             exp_addr.size());
    $display("Test failures found");
    $finish;
  end

  bexkat_cpu u_bexkat_cpu (
    .csi_clk(csi_clk),
    .rsi_reset_n(rsi_reset_n),
    .avm_m0_waitrequest(avm_m0_waitrequest),
    .avm_m0_readdata(avm_m0_readdata),
    .avm_m0_address(avm_m0_address),
    .avm_m0_read(avm_m0_read),
    .avm_m0_write(avm_m0_write),
    .avm_m0_writedata(avm_m0_writedata),
    .avm_m0_byteenable(avm_m0_byteenable)
  );

  tb_mem_model u_mem (
    .csi_clk(csi_clk),
    .address(avm_m0_address),
    .read(avm_m0_read),
    .write(avm_m0_write),
    .writedata(avm_m0_writedata),
    .readdata(avm_m0_readdata),
    .waitrequest(avm_m0_waitrequest)
  );

  task automatic check_write();
    logic [31:0] ea;
    logic [15:0] ed;
    if (exp_addr.size() == 0) begin
      $display("%s: unexpected write of %h at %h", test_name, avm_m0_writedata, avm_m0_address);
      test_err++;
    end else begin
      ea = exp_addr.pop_front();
      ed = exp_data.pop_front();
      assert (avm_m0_address == ea && avm_m0_writedata == ed) else begin
        $display("MISMATCH %s: expected %h at %h, actual %h at %h", test_name, ed, ea,
                 avm_m0_writedata, avm_m0_address);
        test_err++;
      end
    end
  endtask

  task automatic check_read();
    logic [31:0] ra;
    rd_count++;
    if (exp_read.size() != 0) begin
      ra = exp_read.pop_front();
      assert (avm_m0_address == ra) else begin
        $display("MISMATCH %s: expected read at %h, actual %h", test_name, ra, avm_m0_address);
        test_err++;
      end
    end
  endtask

  always @(posedge csi_clk) begin
    if (rsi_reset_n) begin
      if (prev_busy && prev_stall) begin
        assert (avm_m0_read == prev_read && avm_m0_write == !prev_read &&
                avm_m0_address == prev_addr) else begin
          $display("strobe dropped or changed under wait request at %h", prev_addr);
          strobe_err++;
        end
      end
      if (prev_done) begin
        assert (!avm_m0_read && !avm_m0_write) else begin
          $display("strobe still high after its transfer at %h", prev_addr);
          strobe_err++;
        end
      end
      if (avm_m0_read || avm_m0_write) begin
        assert (avm_m0_byteenable == 2'b11) else begin
          $display("MISMATCH %s: expected byteenable %b, actual %b", test_name, 2'b11,
                   avm_m0_byteenable);
          test_err++;
        end
      end
      if (avm_m0_write && !avm_m0_waitrequest)
        check_write();
      if (avm_m0_read && !avm_m0_waitrequest)
        check_read();
    end
    prev_busy = avm_m0_read || avm_m0_write;
    prev_stall = avm_m0_waitrequest;
    prev_read = avm_m0_read;
    prev_addr = avm_m0_address;
    prev_done = prev_busy && !avm_m0_waitrequest;
  end

  function automatic logic [15:0] enc(input logic [2:0] mode, input logic [2:0] op,
                                      input logic [4:0] rb, input logic [4:0] ra);
    return {mode, op, rb, ra};
  endfunction

  function automatic logic [31:0] alu_model(input logic [2:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      bexkat_pkg::AND: return a & b;
      bexkat_pkg::OR:  return a | b;
      bexkat_pkg::ADD: return a + b;
      bexkat_pkg::SUB: return a - b;
      bexkat_pkg::XOR: return a ^ b;
      bexkat_pkg::SHL: return a << b[4:0];
      bexkat_pkg::SHR: return a >> b[4:0];
      default:         return $signed(a) >>> b[4:0];
    endcase
  endfunction

  // branch outcome straight from the compare operands
  function automatic logic cond_taken(input logic [3:0] c, input logic [31:0] a,
                                      input logic [31:0] b);
    case (c)
      bexkat_pkg::BRA:  return 1'b1;
      bexkat_pkg::BEQ:  return a == b;
      bexkat_pkg::BNE:  return a != b;
      bexkat_pkg::BGTU: return a > b;
      bexkat_pkg::BGT:  return $signed(a) > $signed(b);
      bexkat_pkg::BGE:  return $signed(a) >= $signed(b);
      bexkat_pkg::BLE:  return $signed(a) <= $signed(b);
      bexkat_pkg::BLT:  return $signed(a) < $signed(b);
      bexkat_pkg::BGEU: return a >= b;
      bexkat_pkg::BLTU: return a < b;
      bexkat_pkg::BLEU: return a <= b;
      default:          return 1'b0;
    endcase
  endfunction

  task automatic expect_long(input logic [31:0] addr, input logic [31:0] val);
    exp_addr.push_back(addr);
    exp_data.push_back(val[31:16]); // high half first
    exp_addr.push_back(addr + 32'd2);
    exp_data.push_back(val[15:0]);
    shadow[addr] = val;
  endtask

  task automatic ldi(input logic [4:0] ra, input logic [31:0] v);
    prog.push_back(enc(bexkat_pkg::LDI, 3'd0, 5'd0, ra));
    prog.push_back(v[31:16]);
    prog.push_back(v[15:0]);
    rm[ra] = v;
  endtask

  task automatic alu_reg(input logic [2:0] op, input logic [4:0] ra, input logic [4:0] rb,
                         input logic [4:0] rc);
    prog.push_back(enc(bexkat_pkg::REG, op, rb, ra));
    prog.push_back({11'd0, rc});
    rm[ra] = alu_model(op, rm[rb], rm[rc]);
  endtask

  task automatic alu_imm(input logic [2:0] op, input logic [4:0] ra, input logic [4:0] rb,
                         input logic [15:0] imm);
    prog.push_back(enc(bexkat_pkg::IMM, op, rb, ra));
    prog.push_back(imm);
    rm[ra] = alu_model(op, rm[rb], {{16{imm[15]}}, imm});
  endtask

  task automatic inh(input logic [2:0] op, input logic [4:0] ra, input logic [4:0] rb);
    prog.push_back(enc(bexkat_pkg::INH, op, rb, ra));
    case (op)
      bexkat_pkg::CMP: begin
        cmp_a = rm[ra];
        cmp_b = rm[rb];
      end
      bexkat_pkg::INC: rm[ra] = rm[ra] + 32'd1;
      bexkat_pkg::DEC: rm[ra] = rm[ra] - 32'd1;
      bexkat_pkg::MOV: rm[ra] = rm[rb];
      bexkat_pkg::PUSH: begin
        rm[31] = rm[31] - 32'd4;
        expect_long(rm[31], rm[ra]);
      end
      bexkat_pkg::POP: begin
        rm[ra] = shadow[rm[31]];
        rm[31] = rm[31] + 32'd4;
      end
      default: ;
    endcase
  endtask

  task automatic mem_regind(input logic [2:0] op, input logic [4:0] ra, input logic [4:0] rb,
                            input logic [15:0] off);
    logic [31:0] ea;
    ea = rm[rb] + {{16{off[15]}}, off};
    prog.push_back(enc(bexkat_pkg::REGIND, op, rb, ra));
    prog.push_back(off);
    if (op == bexkat_pkg::ST_L)
      expect_long(ea, rm[ra]);
    else if (op == bexkat_pkg::LD_L)
      rm[ra] = shadow[ea];
    else if (op == bexkat_pkg::LDA)
      rm[ra] = ea;
  endtask

  task automatic mem_dir(input logic [2:0] op, input logic [4:0] ra, input logic [31:0] addr,
                         input logic expect_it);
    prog.push_back(enc(bexkat_pkg::DIR, op, 5'd0, ra));
    prog.push_back(addr[31:16]);
    prog.push_back(addr[15:0]);
    if (op == bexkat_pkg::ST_L && expect_it)
      expect_long(addr, rm[ra]);
    else if (op == bexkat_pkg::LD_L)
      rm[ra] = shadow[addr];
  endtask

  task automatic branch(input logic [3:0] c, input logic [15:0] off);
    prog.push_back(enc(bexkat_pkg::BRANCH, 3'd0, 5'd0, {1'b0, c}));
    prog.push_back(off);
  endtask

  task automatic new_program(input string name);
    test_name = name;
    test_err = 0;
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    exp_read.delete();
    shadow.delete();
    for (int i = 0; i < 32; i++)
      rm[i] = 32'd0;
  endtask

  task automatic start_program();
    int n;
    @(negedge csi_clk);
    wd_cycles = 0;
    wd_limit = 8 * prog.size() + 8 * exp_addr.size() + 100; // worst case 6 cycles per word
    rsi_reset_n = 1'b0;
    for (int i = 0; i < 16384; i++)
      u_mem.mem[i] = 16'(i * 40503) ^ 16'h5a3c;
    foreach (prog[i])
      u_mem.mem[i] = prog[i]; // RESET_PC maps to word 0
    rd_count = 0;
    repeat (4) @(negedge csi_clk);
    rsi_reset_n = 1'b1;
    n = 0;
    while (!avm_m0_read && n < 3) begin
      assert (!avm_m0_write) else begin
        $display("%s: write strobe before the first fetch", test_name);
        test_err++;
      end
      @(negedge csi_clk);
      n++;
    end
    assert (avm_m0_read && n <= 2 && avm_m0_address == bexkat_pkg::RESET_PC) else begin
      $display("%s: first fetch at reset address missing or late", test_name);
      test_err++;
    end
  endtask

  task automatic report();
    if (test_err == 0) begin
      passes++;
      $display("test %-12s PASS", test_name);
    end else begin
      fails++;
      $display("test %-12s FAIL (%0d errors)", test_name, test_err);
    end
  endtask

  task automatic finish_test();
    while (exp_addr.size() != 0)
      @(negedge csi_clk);
    repeat (20) @(negedge csi_clk); // catch stray writes
    if (exp_read.size() != 0) begin
      $display("%s: %0d expected fetches never came", test_name, exp_read.size());
      test_err++;
    end
    report();
  endtask

  task automatic halt();
    branch(bexkat_pkg::BRA, 16'hfffc); // spin on itself
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] pa [4];
    logic [31:0] pb [4];
    logic [31:0] tgt;
    logic tk;
    rsi_reset_n = 1'b0;
    passes = 0;
    fails = 0;
    strobe_err = 0;
    pa = '{32'd5, 32'd7, 32'hffffffff, 32'd3};
    pb = '{32'd7, 32'd5, 32'd1, 32'd3};

    new_program("reset_fetch");
    repeat (5) inh(bexkat_pkg::NOP, 5'd0, 5'd0);
    mem_dir(bexkat_pkg::ST_L, 5'd0, DATA_BASE, 1'b1);
    halt();
    for (int k = 0; k < 8; k++)
      exp_read.push_back(bexkat_pkg::RESET_PC + 32'(2 * k));
    start_program();
    finish_test();

    new_program("alu");
    ldi(5'd1, 32'h8765_4321);
    ldi(5'd2, 32'h0000_0013);
    a = DATA_BASE;
    for (int op = 0; op < 8; op++) begin
      alu_reg(3'(op), 5'd3, 5'd1, 5'd2);
      mem_dir(bexkat_pkg::ST_L, 5'd3, a, 1'b1);
      alu_imm(3'(op), 5'd4, 5'd1, 16'hfff3);
      mem_dir(bexkat_pkg::ST_L, 5'd4, a + 32'd4, 1'b1);
      a = a + 32'd8;
    end
    inh(bexkat_pkg::INC, 5'd5, 5'd0);
    inh(bexkat_pkg::DEC, 5'd6, 5'd0);
    inh(bexkat_pkg::MOV, 5'd7, 5'd1);
    mem_dir(bexkat_pkg::ST_L, 5'd5, a, 1'b1);
    mem_dir(bexkat_pkg::ST_L, 5'd6, a + 32'd4, 1'b1);
    mem_dir(bexkat_pkg::ST_L, 5'd7, a + 32'd8, 1'b1);
    halt();
    start_program();
    finish_test();

    new_program("branch");
    ldi(5'd5, 32'h1111_1111);
    ldi(5'd6, 32'h2222_2222);
    for (int c = 0; c < 12; c++) begin
      for (int p = 0; p < 4; p++) begin
        ldi(5'd1, pa[p]);
        ldi(5'd2, pb[p]);
        inh(bexkat_pkg::CMP, 5'd1, 5'd2);
        tk = cond_taken(4'(c), cmp_a, cmp_b);
        branch(4'(c), 16'd6); // skips one direct store
        mem_dir(bexkat_pkg::ST_L, 5'd5, DATA_BASE, !tk);
        mem_dir(bexkat_pkg::ST_L, 5'd6, DATA_BASE + 32'd4, 1'b1);
      end
    end
    halt();
    start_program();
    finish_test();

    new_program("memory");
    ldi(5'd1, DATA_BASE + 32'h100);
    ldi(5'd2, 32'hcafe_f00d);
    ldi(5'd3, 32'h1234_5678);
    mem_regind(bexkat_pkg::ST_L, 5'd2, 5'd1, 16'h0010);
    mem_regind(bexkat_pkg::ST_L, 5'd3, 5'd1, 16'hfff0);
    mem_regind(bexkat_pkg::LD_L, 5'd4, 5'd1, 16'h0010);
    mem_regind(bexkat_pkg::LD_L, 5'd5, 5'd1, 16'hfff0);
    mem_dir(bexkat_pkg::ST_L, 5'd4, DATA_BASE + 32'h200, 1'b1);
    mem_dir(bexkat_pkg::ST_L, 5'd5, DATA_BASE + 32'h204, 1'b1);
    mem_dir(bexkat_pkg::ST_L, 5'd2, DATA_BASE + 32'h300, 1'b1);
    mem_dir(bexkat_pkg::LD_L, 5'd6, DATA_BASE + 32'h300, 1'b0);
    mem_dir(bexkat_pkg::ST_L, 5'd6, DATA_BASE + 32'h304, 1'b1);
    mem_regind(bexkat_pkg::LDA, 5'd7, 5'd1, 16'hff80);
    mem_dir(bexkat_pkg::ST_L, 5'd7, DATA_BASE + 32'h308, 1'b1);
    // ldi, jmp and the skipped store come before the target
    tgt = bexkat_pkg::RESET_PC + 32'(2 * (prog.size() + 3 + 2 + 3));
    ldi(5'd8, tgt);
    mem_regind(bexkat_pkg::JMP, 5'd0, 5'd8, 16'h0000);
    mem_dir(bexkat_pkg::ST_L, 5'd2, DATA_BASE + 32'h400, 1'b0);
    mem_dir(bexkat_pkg::ST_L, 5'd3, DATA_BASE + 32'h404, 1'b1);
    tgt = bexkat_pkg::RESET_PC + 32'(2 * (prog.size() + 3 + 3));
    mem_dir(bexkat_pkg::JMP, 5'd0, tgt, 1'b0);
    mem_dir(bexkat_pkg::ST_L, 5'd2, DATA_BASE + 32'h408, 1'b0);
    mem_dir(bexkat_pkg::ST_L, 5'd3, DATA_BASE + 32'h40c, 1'b1);
    halt();
    start_program();
    finish_test();

    new_program("stack");
    ldi(5'd31, STACK_TOP);
    ldi(5'd1, 32'hdead_beef);
    ldi(5'd2, 32'h0bad_f00d);
    inh(bexkat_pkg::PUSH, 5'd1, 5'd0);
    inh(bexkat_pkg::PUSH, 5'd2, 5'd0);
    inh(bexkat_pkg::POP, 5'd3, 5'd0);
    inh(bexkat_pkg::POP, 5'd4, 5'd0);
    mem_dir(bexkat_pkg::ST_L, 5'd3, DATA_BASE, 1'b1);
    mem_dir(bexkat_pkg::ST_L, 5'd4, DATA_BASE + 32'd4, 1'b1);
    mem_dir(bexkat_pkg::ST_L, 5'd31, DATA_BASE + 32'd8, 1'b1);
    halt();
    start_program();
    finish_test();

    new_program("fault");
    prog.push_back(16'he000); // mode 7
    repeat (4) inh(bexkat_pkg::NOP, 5'd0, 5'd0);
    start_program();
    while (rd_count < 1)
      @(negedge csi_clk);
    repeat (50) begin
      @(negedge csi_clk);
      assert (!avm_m0_read && !avm_m0_write) else begin
        $display("fault: strobe at %h after a reserved mode", avm_m0_address);
        test_err++;
      end
    end
    report();

    test_name = "strobe_hold";
    test_err = strobe_err;
    report();

    $display("%0d tests passed, %0d tests failed", passes, fails);
    if (fails == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
  input  logic        csi_clk,
  input  logic [31:0] address,
  input  logic        read,
  input  logic        write,
  input  logic [15:0] writedata,
  output logic [15:0] readdata,
  output logic        waitrequest
);

  logic [15:0] mem [16384]; // 32 KB window, aliased over the address space
  logic [31:0] lfsr;
  logic        busy;
  logic        b_hi;
  logic        b_lo;
  int          stall;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  initial begin
    lfsr = 32'h313168d4;
    busy = 1'b0;
    stall = 0;
    readdata = 16'h0000;
    waitrequest = 1'b1;
  end

  // everything changes on the falling edge, the core samples on the rising one
  always @(negedge csi_clk) begin
    if (read || write) begin
      if (!busy) begin
        busy = 1'b1;
        lfsr = lfsr_step(lfsr);
        b_hi = lfsr[0];
        lfsr = lfsr_step(lfsr);
        b_lo = lfsr[0];
        stall = {b_hi, b_lo}; // 0 to 3 wait cycles
      end else if (stall > 0) begin
        stall--;
      end
      waitrequest = (stall != 0);
      if (stall == 0) begin
        if (read)
          readdata = mem[address[14:1]];
        else
          mem[address[14:1]] = writedata;
      end
    end else begin
      busy = 1'b0;
      waitrequest = 1'b1;
    end
  end

endmodule

//--- bexkat_cpu.sv
`timescale 1ns/1ps

module bexkat_cpu (
  input  logic                          csi_clk,
  input  logic                          rsi_reset_n,
  input  logic                          avm_m0_waitrequest,
  input  logic [bexkat_pkg::BUS_W-1:0]  avm_m0_readdata,
  output logic [bexkat_pkg::DATA_W-1:0] avm_m0_address,
  output logic                          avm_m0_read,
  output logic                          avm_m0_write,
  output logic [bexkat_pkg::BUS_W-1:0]  avm_m0_writedata,
  output logic [1:0]                    avm_m0_byteenable
);

  logic [bexkat_pkg::REG_AW-1:0] rd_addr1, rd_addr2, wr_addr;
  logic [bexkat_pkg::DATA_W-1:0] wr_data, rd_data1, rd_data2;
  logic wr_en;
  logic [bexkat_pkg::DATA_W-1:0] alu_in2, alu_out;
  bexkat_pkg::alu_op_e alu_op;
  logic alu_carry, alu_negative, alu_overflow, alu_zero;
  logic flags_load, taken;
  bexkat_pkg::cond_e cond;

  bexkat_control u_control (
    .csi_clk(csi_clk),
    .rsi_reset_n(rsi_reset_n),
    .avm_m0_waitrequest(avm_m0_waitrequest),
    .avm_m0_readdata(avm_m0_readdata),
    .avm_m0_address(avm_m0_address),
    .avm_m0_read(avm_m0_read),
    .avm_m0_write(avm_m0_write),
    .avm_m0_writedata(avm_m0_writedata),
    .avm_m0_byteenable(avm_m0_byteenable),
    .rd_addr1(rd_addr1),
    .rd_addr2(rd_addr2),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .wr_en(wr_en),
    .rd_data1(rd_data1),
    .rd_data2(rd_data2),
    .alu_in2(alu_in2),
    .alu_op(alu_op),
    .alu_out(alu_out),
    .flags_load(flags_load),
    .cond(cond),
    .taken(taken)
  );

  bexkat_alu u_alu (
    .in1(rd_data1),
    .in2(alu_in2),
    .op(alu_op),
    .out(alu_out),
    .carry(alu_carry),
    .negative(alu_negative),
    .overflow(alu_overflow),
    .zero(alu_zero)
  );

  bexkat_regfile u_regfile (
    .csi_clk(csi_clk),
    .rsi_reset_n(rsi_reset_n),
    .read_addr1(rd_addr1),
    .read_addr2(rd_addr2),
    .write_addr(wr_addr),
    .write_data(wr_data),
    .write_en(wr_en),
    .data1(rd_data1),
    .data2(rd_data2)
  );

  bexkat_cond u_cond (
    .csi_clk(csi_clk),
    .rsi_reset_n(rsi_reset_n),
    .load(flags_load),
    .carry(alu_carry),
    .negative(alu_negative),
    .overflow(alu_overflow),
    .zero(alu_zero),
    .cond(cond),
    .taken(taken)
  );

endmodule

//--- bexkat_control.sv
`timescale 1ns/1ps

module bexkat_control (
  input  logic                          csi_clk,
  input  logic                          rsi_reset_n,
  input  logic                          avm_m0_waitrequest,
  input  logic [bexkat_pkg::BUS_W-1:0]  avm_m0_readdata,
  output logic [bexkat_pkg::DATA_W-1:0] avm_m0_address,
  output logic                          avm_m0_read,
  output logic                          avm_m0_write,
  output logic [bexkat_pkg::BUS_W-1:0]  avm_m0_writedata,
  output logic [1:0]                    avm_m0_byteenable,
  output logic [bexkat_pkg::REG_AW-1:0] rd_addr1,
  output logic [bexkat_pkg::REG_AW-1:0] rd_addr2,
  output logic [bexkat_pkg::REG_AW-1:0] wr_addr,
  output logic [bexkat_pkg::DATA_W-1:0] wr_data,
  output logic                          wr_en,
  input  logic [bexkat_pkg::DATA_W-1:0] rd_data1,
  input  logic [bexkat_pkg::DATA_W-1:0] rd_data2,
  output logic [bexkat_pkg::DATA_W-1:0] alu_in2,
  output bexkat_pkg::alu_op_e           alu_op,
  input  logic [bexkat_pkg::DATA_W-1:0] alu_out,
  output logic                          flags_load,
  output bexkat_pkg::cond_e             cond,
  input  logic                          taken
);

  bexkat_pkg::state_e state, state_next;
  bexkat_pkg::state_e retstate, retstate_next;
  logic [bexkat_pkg::DATA_W-1:0] pc, pc_next;
  logic [bexkat_pkg::BUS_W-1:0] ir, ir_next;
  logic [bexkat_pkg::DATA_W-1:0] mar, mar_next;
  logic [bexkat_pkg::DATA_W-1:0] mdr, mdr_next;
  logic addrsel, addrsel_next; // high drives mar onto the bus
  logic mdr_low, mdr_low_next;
  logic read_next, write_next;
  logic mem_go;
  logic [bexkat_pkg::DATA_W-1:0] ea;
  bexkat_pkg::mode_e ir_mode;
  logic [2:0] ir_op;
  logic [bexkat_pkg::REG_AW-1:0] ir_ra, ir_rb;

  assign ir_mode = bexkat_pkg::mode_e'(ir[15:13]);
  assign ir_op = ir[12:10];
  assign ir_rb = ir[9:5];
  assign ir_ra = ir[4:0];
  assign ea = (ir_mode == bexkat_pkg::DIR) ? mar : alu_out; // rB + offset otherwise
  assign cond = bexkat_pkg::cond_e'(ir[3:0]);

  assign avm_m0_address = addrsel ? mar : pc;
  assign avm_m0_writedata = mdr_low ? mdr[15:0] : mdr[31:16];
  assign avm_m0_byteenable = 2'b11;

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      state <= bexkat_pkg::FETCH1;
      retstate <= bexkat_pkg::FETCH1;
      pc <= bexkat_pkg::RESET_PC;
      addrsel <= 1'b0;
      mdr_low <= 1'b0;
      avm_m0_read <= 1'b0;
      avm_m0_write <= 1'b0;
    end else begin
      state <= state_next;
      retstate <= retstate_next;
      pc <= pc_next;
      addrsel <= addrsel_next;
      mdr_low <= mdr_low_next;
      avm_m0_read <= read_next;
      avm_m0_write <= write_next;
    end
  end

  always_ff @(posedge csi_clk) begin
    ir <= ir_next;
    mar <= mar_next;
    mdr <= mdr_next;
  end

  always_comb begin
    state_next = state;
    retstate_next = retstate;
    pc_next = pc;
    ir_next = ir;
    mar_next = mar;
    mdr_next = mdr;
    addrsel_next = addrsel;
    mdr_low_next = mdr_low;
    read_next = avm_m0_read;
    write_next = avm_m0_write;
    rd_addr1 = ir_rb;
    rd_addr2 = ir_ra;
    alu_in2 = mar;
    alu_op = bexkat_pkg::ADD;
    wr_addr = ir_ra;
    wr_data = alu_out;
    wr_en = 1'b0;
    flags_load = 1'b0;
    mem_go = 1'b0;

    case (state)
      bexkat_pkg::FETCH1, bexkat_pkg::FETCH2, bexkat_pkg::FETCH3: begin
        state_next = bexkat_pkg::MEMLOAD;
        read_next = 1'b1;
        addrsel_next = 1'b0;
        if (state == bexkat_pkg::FETCH1)
          retstate_next = bexkat_pkg::EVAL1;
        else if (state == bexkat_pkg::FETCH2)
          retstate_next = bexkat_pkg::EVAL2;
        else
          retstate_next = bexkat_pkg::EVAL3;
      end
      bexkat_pkg::MEMLOAD: begin
        if (!avm_m0_waitrequest) begin
          state_next = retstate;
          read_next = 1'b0;
          case (retstate)
            bexkat_pkg::EVAL1: begin
              ir_next = avm_m0_readdata;
              pc_next = pc + 32'd2;
            end
            bexkat_pkg::EVAL2: begin
              mar_next = {{16{avm_m0_readdata[15]}}, avm_m0_readdata}; // sign extended
              pc_next = pc + 32'd2;
            end
            bexkat_pkg::EVAL3: begin
              mar_next = {mar[15:0], avm_m0_readdata};
              pc_next = pc + 32'd2;
            end
            bexkat_pkg::LOAD2, bexkat_pkg::POP2:
              mdr_next[31:16] = avm_m0_readdata; // high half
            default: begin
              wr_data = {mdr[31:16], avm_m0_readdata}; // low half done, whole word to rA
              wr_en = 1'b1;
            end
          endcase
        end
      end
      bexkat_pkg::MEMSAVE: begin
        if (!avm_m0_waitrequest) begin
          state_next = retstate;
          write_next = 1'b0;
        end
      end
      bexkat_pkg::EVAL1: begin
        if (ir_mode == bexkat_pkg::RSVD) begin
          state_next = bexkat_pkg::FAULT;
        end else if (ir_mode != bexkat_pkg::INH) begin
          state_next = bexkat_pkg::FETCH2;
        end else begin
          state_next = bexkat_pkg::FETCH1;
          case (bexkat_pkg::inh_op_e'(ir_op))
            bexkat_pkg::NOP: ;
            bexkat_pkg::CMP: begin
              rd_addr1 = ir_ra;
              rd_addr2 = ir_rb;
              alu_in2 = rd_data2;
              alu_op = bexkat_pkg::SUB;
              flags_load = 1'b1;
            end
            bexkat_pkg::INC, bexkat_pkg::DEC: begin
              rd_addr1 = ir_ra;
              alu_in2 = 32'd1;
              if (ir_op == bexkat_pkg::DEC)
                alu_op = bexkat_pkg::SUB;
              wr_en = 1'b1;
            end
            bexkat_pkg::PUSH: begin
              rd_addr1 = bexkat_pkg::REG_SP;
              alu_in2 = 32'd4;
              alu_op = bexkat_pkg::SUB;
              wr_addr = bexkat_pkg::REG_SP; // sp - 4 before the write
              wr_en = 1'b1;
              mar_next = alu_out;
              mdr_next = rd_data2;
              mdr_low_next = 1'b0;
              addrsel_next = 1'b1;
              write_next = 1'b1;
              retstate_next = bexkat_pkg::PUSH2;
              state_next = bexkat_pkg::MEMSAVE;
            end
            bexkat_pkg::POP: begin
              rd_addr1 = bexkat_pkg::REG_SP;
              mar_next = rd_data1;
              addrsel_next = 1'b1;
              read_next = 1'b1;
              retstate_next = bexkat_pkg::POP2;
              state_next = bexkat_pkg::MEMLOAD;
            end
            bexkat_pkg::MOV: begin
              wr_data = rd_data1;
              wr_en = 1'b1;
            end
            default: state_next = bexkat_pkg::FAULT;
          endcase
        end
      end
      bexkat_pkg::EVAL2: begin
        state_next = bexkat_pkg::FETCH1;
        case (ir_mode)
          bexkat_pkg::REG: begin
            rd_addr2 = mar[4:0]; // rC
            alu_in2 = rd_data2;
            alu_op = bexkat_pkg::alu_op_e'(ir_op);
            wr_en = 1'b1;
          end
          bexkat_pkg::IMM: begin
            alu_op = bexkat_pkg::alu_op_e'(ir_op);
            wr_en = 1'b1;
          end
          bexkat_pkg::BRANCH: begin
            if (ir[3:0] > 4'd11)
              state_next = bexkat_pkg::FAULT;
            else if (taken)
              pc_next = pc + mar;
          end
          bexkat_pkg::REGIND: mem_go = 1'b1;
          bexkat_pkg::LDI, bexkat_pkg::DIR: state_next = bexkat_pkg::FETCH3;
          default: state_next = bexkat_pkg::FAULT;
        endcase
      end
      bexkat_pkg::EVAL3: begin
        if (ir_mode == bexkat_pkg::DIR) begin
          mem_go = 1'b1;
        end else begin
          wr_data = mar; // ldi
          wr_en = 1'b1;
          state_next = bexkat_pkg::FETCH1;
        end
      end
      bexkat_pkg::LOAD2, bexkat_pkg::POP2: begin
        mar_next = mar + 32'd2;
        read_next = 1'b1;
        retstate_next = bexkat_pkg::FETCH1;
        state_next = bexkat_pkg::MEMLOAD;
        if (state == bexkat_pkg::POP2) begin
          rd_addr1 = bexkat_pkg::REG_SP;
          alu_in2 = 32'd4;
          wr_addr = bexkat_pkg::REG_SP;
          wr_en = 1'b1;
        end
      end
      bexkat_pkg::STORE2, bexkat_pkg::PUSH2: begin
        mar_next = mar + 32'd2;
        mdr_low_next = 1'b1;
        write_next = 1'b1;
        retstate_next = bexkat_pkg::FETCH1;
        state_next = bexkat_pkg::MEMSAVE;
      end
      default: state_next = bexkat_pkg::FAULT; // stuck, no strobes
    endcase

    if (mem_go) begin
      state_next = bexkat_pkg::FETCH1;
      case (bexkat_pkg::mem_op_e'(ir_op))
        bexkat_pkg::ST_L: begin
          mar_next = ea;
          mdr_next = rd_data2;
          mdr_low_next = 1'b0;
          addrsel_next = 1'b1;
          write_next = 1'b1;
          retstate_next = bexkat_pkg::STORE2;
          state_next = bexkat_pkg::MEMSAVE;
        end
        bexkat_pkg::LD_L: begin
          mar_next = ea;
          addrsel_next = 1'b1;
          read_next = 1'b1;
          retstate_next = bexkat_pkg::LOAD2;
          state_next = bexkat_pkg::MEMLOAD;
        end
        bexkat_pkg::LDA: begin
          if (ir_mode == bexkat_pkg::REGIND) begin
            wr_data = ea;
            wr_en = 1'b1;
          end else begin
            state_next = bexkat_pkg::FAULT;
          end
        end
        bexkat_pkg::JMP: pc_next = ea;
        default: state_next = bexkat_pkg::FAULT;
      endcase
    end
  end

endmodule

//--- bexkat_cond.sv
`timescale 1ns/1ps

module bexkat_cond (
  input  logic              csi_clk,
  input  logic              rsi_reset_n,
  input  logic              load,
  input  logic              carry,
  input  logic              negative,
  input  logic              overflow,
  input  logic              zero,
  input  bexkat_pkg::cond_e cond,
  output logic              taken
);

  logic c, n, v, z;

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      {c, n, v, z} <= 4'b0000;
    end else if (load) begin
      {c, n, v, z} <= {carry, negative, overflow, zero};
    end
  end

  always_comb begin
    case (cond)
      bexkat_pkg::BRA:  taken = 1'b1;
      bexkat_pkg::BEQ:  taken = z;
      bexkat_pkg::BNE:  taken = ~z;
      bexkat_pkg::BGTU: taken = ~(z | c);
      bexkat_pkg::BGT:  taken = ~(z | (n ^ v));
      bexkat_pkg::BGE:  taken = ~(n ^ v);
      bexkat_pkg::BLE:  taken = z | (n ^ v);
      bexkat_pkg::BLT:  taken = n ^ v;
      bexkat_pkg::BGEU: taken = ~c;
      bexkat_pkg::BLTU: taken = c;
      bexkat_pkg::BLEU: taken = c | z;
      default:          taken = 1'b0; // brn and unused codes
    endcase
  end

endmodule

//--- bexkat_regfile.sv
`timescale 1ns/1ps

module bexkat_regfile (
  input  logic                          csi_clk,
  input  logic                          rsi_reset_n,
  input  logic [bexkat_pkg::REG_AW-1:0] read_addr1,
  input  logic [bexkat_pkg::REG_AW-1:0] read_addr2,
  input  logic [bexkat_pkg::REG_AW-1:0] write_addr,
  input  logic [bexkat_pkg::DATA_W-1:0] write_data,
  input  logic                          write_en,
  output logic [bexkat_pkg::DATA_W-1:0] data1,
  output logic [bexkat_pkg::DATA_W-1:0] data2
);

  logic [bexkat_pkg::DATA_W-1:0] regs [2**bexkat_pkg::REG_AW];

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      for (int i = 0; i < 2**bexkat_pkg::REG_AW; i++)
        regs[i] <= '0;
    end else if (write_en) begin
      regs[write_addr] <= write_data;
    end
  end

  assign data1 = regs[read_addr1]; // async read
  assign data2 = regs[read_addr2];

endmodule

//--- bexkat_alu.sv
`timescale 1ns/1ps

module bexkat_alu (
  input  logic [bexkat_pkg::DATA_W-1:0] in1,
  input  logic [bexkat_pkg::DATA_W-1:0] in2,
  input  bexkat_pkg::alu_op_e           op,
  output logic [bexkat_pkg::DATA_W-1:0] out,
  output logic                          carry,
  output logic                          negative,
  output logic                          overflow,
  output logic                          zero
);

  logic [bexkat_pkg::DATA_W-1:0] diff;
  logic [4:0] shamt;

  assign {carry, diff} = {1'b0, in1} - {1'b0, in2}; // borrow when in1 < in2
  assign negative = diff[bexkat_pkg::DATA_W-1];
  assign overflow = (in1[bexkat_pkg::DATA_W-1] != in2[bexkat_pkg::DATA_W-1]) &&
                    (diff[bexkat_pkg::DATA_W-1] != in1[bexkat_pkg::DATA_W-1]);
  assign zero = (diff == '0);
  assign shamt = in2[4:0];

  always_comb begin
    case (op)
      bexkat_pkg::AND: out = in1 & in2;
      bexkat_pkg::OR:  out = in1 | in2;
      bexkat_pkg::SUB: out = diff;
      bexkat_pkg::XOR: out = in1 ^ in2;
      bexkat_pkg::SHL: out = in1 << shamt;
      bexkat_pkg::SHR: out = in1 >> shamt;
      bexkat_pkg::ASR: out = $signed(in1) >>> shamt;
      default:         out = in1 + in2; // add
    endcase
  end

endmodule

//--- bexkat_pkg.sv
package bexkat_pkg;

  localparam int DATA_W = 32;
  localparam int BUS_W = 16;
  localparam int REG_AW = 5;

  localparam logic [DATA_W-1:0] RESET_PC = 32'hffc00000; // base of boot rom
  localparam logic [REG_AW-1:0] REG_SP = 5'd31;

  typedef enum logic [3:0] {
    FETCH1,
    FETCH2,
    FETCH3,
    MEMLOAD,
    MEMSAVE,
    EVAL1,
    EVAL2,
    EVAL3,
    LOAD2,
    STORE2,
    PUSH2,
    POP2,
    FAULT
  } state_e;

  // word 0 bits 15:13
  typedef enum logic [2:0] {
    INH    = 3'd0,
    REG    = 3'd1, // rC in word 1
    IMM    = 3'd2,
    LDI    = 3'd3, // high word first
    BRANCH = 3'd4,
    REGIND = 3'd5,
    DIR    = 3'd6,
    RSVD   = 3'd7
  } mode_e;

  typedef enum logic [2:0] {NOP, CMP, INC, DEC, PUSH, POP, MOV} inh_op_e;

  typedef enum logic [2:0] {AND, OR, ADD, SUB, XOR, SHL, SHR, ASR} alu_op_e;

  typedef enum logic [2:0] {ST_L, LD_L, LDA, JMP} mem_op_e;

  typedef enum logic [3:0] {
    BRA,
    BEQ,
    BNE,
    BGTU,
    BGT,
    BGE,
    BLE,
    BLT,
    BGEU,
    BLTU,
    BLEU,
    BRN
  } cond_e;

endpackage
